// ==== rtl/snake_seg_cfg.svh ====
`ifndef SNAKE_SEG_CFG_SVH
`define SNAKE_SEG_CFG_SVH

// Consecutive high samples that make a press
`define SNAKE_DEBOUNCE_LEN 4

// Free-running divider width, one tick per wrap
`define SNAKE_DIV_BITS 3

// Ticks spent with only G lit before moving
`define SNAKE_START_TICKS 3

// Ticks after the trail empties before waiting again
`define SNAKE_CLEAR_TICKS 1

`endif

// ==== rtl/snake_seg_pkg.sv ====
package snake_seg_pkg;

    // Segment position on the figure-eight
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_idx_t;

    // Direction the snake is travelling
    typedef enum logic [1:0] {
        HEAD_RIGHT = 2'd0,
        HEAD_LEFT  = 2'd1,
        HEAD_UP    = 2'd2,
        HEAD_DOWN  = 2'd3
    } heading_t;

    typedef enum logic [1:0] {
        PH_WAIT = 2'd0,
        PH_MOVE = 2'd1,
        PH_FALL = 2'd2
    } phase_t;

    // One bit per segment, bit 0 is A
    typedef union packed {
        logic [6:0] raw;
        struct packed {
            logic g;
            logic f;
            logic e;
            logic d;
            logic c;
            logic b;
            logic a;
        } bits;
    } seg_word_u;

endpackage

// ==== rtl/button_conditioner.sv ====
`timescale 1ns/10ps
`include "snake_seg_cfg.svh"

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic btn_right,
    input  logic btn_left,
    input  logic btn_up,
    input  logic btn_down,
    output logic press_right,
    output logic press_left,
    output logic press_up,
    output logic press_down
);

    logic [3:0] btn_vec;
    logic [3:0] press_vec;

    assign btn_vec = {btn_down, btn_up, btn_left, btn_right};

    genvar i;
    generate
        for (i = 0; i < 4; i++) begin : g_chan
            logic [`SNAKE_DEBOUNCE_LEN-1:0] shift_q;
            logic                           level_q;
            logic                           pulse_q;
            logic                           stable;

            // Level counts as pressed once the whole window is high
            assign stable = &shift_q;

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    shift_q <= '0;
                    level_q <= 1'b0;
                    pulse_q <= 1'b0;
                end else begin
                    shift_q <= {shift_q[`SNAKE_DEBOUNCE_LEN-2:0], btn_vec[i]};
                    level_q <= stable;
                    pulse_q <= stable & ~level_q;
                end
            end

            assign press_vec[i] = pulse_q;
        end
    endgenerate

    assign press_right = press_vec[0];
    assign press_left  = press_vec[1];
    assign press_up    = press_vec[2];
    assign press_down  = press_vec[3];

endmodule

// ==== rtl/segment_walker.sv ====
`timescale 1ns/10ps

module segment_walker (
    input  logic                    clk,
    input  logic                    rst,
    input  snake_seg_pkg::phase_t   phase,
    input  logic                    press_right,
    input  logic                    press_left,
    input  logic                    press_up,
    output snake_seg_pkg::seg_idx_t pos,
    output snake_seg_pkg::heading_t heading
);

    localparam logic [1:0] BTN_NONE = 2'd0;
    localparam logic [1:0] BTN_R    = 2'd1;
    localparam logic [1:0] BTN_L    = 2'd2;
    localparam logic [1:0] BTN_U    = 2'd3;

    logic [1:0] btn;
    logic [4:0] nxt;

    // Simultaneous pulses resolve right first, then left
    always_comb begin
        if (press_right) begin
            btn = BTN_R;
        end else if (press_left) begin
            btn = BTN_L;
        end else if (press_up) begin
            btn = BTN_U;
        end else begin
            btn = BTN_NONE;
        end
    end

    // Move table, next {position, heading}
    always_comb begin
        case ({pos, heading, btn})
            {snake_seg_pkg::SEG_A, snake_seg_pkg::HEAD_RIGHT, BTN_R}:
                nxt = {snake_seg_pkg::SEG_B, snake_seg_pkg::HEAD_DOWN};
            {snake_seg_pkg::SEG_A, snake_seg_pkg::HEAD_LEFT, BTN_L}:
                nxt = {snake_seg_pkg::SEG_F, snake_seg_pkg::HEAD_DOWN};
            {snake_seg_pkg::SEG_B, snake_seg_pkg::HEAD_UP, BTN_L}:
                nxt = {snake_seg_pkg::SEG_A, snake_seg_pkg::HEAD_LEFT};
            {snake_seg_pkg::SEG_B, snake_seg_pkg::HEAD_DOWN, BTN_R}:
                nxt = {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_LEFT};
            {snake_seg_pkg::SEG_B, snake_seg_pkg::HEAD_DOWN, BTN_U}:
                nxt = {snake_seg_pkg::SEG_C, snake_seg_pkg::HEAD_DOWN};
            {snake_seg_pkg::SEG_C, snake_seg_pkg::HEAD_UP, BTN_L}:
                nxt = {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_LEFT};
            {snake_seg_pkg::SEG_C, snake_seg_pkg::HEAD_UP, BTN_U}:
                nxt = {snake_seg_pkg::SEG_B, snake_seg_pkg::HEAD_UP};
            {snake_seg_pkg::SEG_C, snake_seg_pkg::HEAD_DOWN, BTN_R}:
                nxt = {snake_seg_pkg::SEG_D, snake_seg_pkg::HEAD_DOWN};
            {snake_seg_pkg::SEG_D, snake_seg_pkg::HEAD_RIGHT, BTN_L}:
                nxt = {snake_seg_pkg::SEG_C, snake_seg_pkg::HEAD_UP};
            {snake_seg_pkg::SEG_D, snake_seg_pkg::HEAD_LEFT, BTN_R}:
                nxt = {snake_seg_pkg::SEG_E, snake_seg_pkg::HEAD_UP};
            {snake_seg_pkg::SEG_E, snake_seg_pkg::HEAD_UP, BTN_R}:
                nxt = {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_RIGHT};
            {snake_seg_pkg::SEG_E, snake_seg_pkg::HEAD_UP, BTN_U}:
                nxt = {snake_seg_pkg::SEG_F, snake_seg_pkg::HEAD_UP};
            {snake_seg_pkg::SEG_E, snake_seg_pkg::HEAD_DOWN, BTN_L}:
                nxt = {snake_seg_pkg::SEG_D, snake_seg_pkg::HEAD_RIGHT};
            {snake_seg_pkg::SEG_F, snake_seg_pkg::HEAD_UP, BTN_R}:
                nxt = {snake_seg_pkg::SEG_A, snake_seg_pkg::HEAD_RIGHT};
            {snake_seg_pkg::SEG_F, snake_seg_pkg::HEAD_DOWN, BTN_L}:
                nxt = {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_RIGHT};
            {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_RIGHT, BTN_L}:
                nxt = {snake_seg_pkg::SEG_B, snake_seg_pkg::HEAD_UP};
            {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_RIGHT, BTN_R}:
                nxt = {snake_seg_pkg::SEG_C, snake_seg_pkg::HEAD_DOWN};
            {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_LEFT, BTN_L}:
                nxt = {snake_seg_pkg::SEG_E, snake_seg_pkg::HEAD_DOWN};
            {snake_seg_pkg::SEG_G, snake_seg_pkg::HEAD_LEFT, BTN_R}:
                nxt = {snake_seg_pkg::SEG_F, snake_seg_pkg::HEAD_UP};
            default:
                nxt = {pos, heading};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos     <= snake_seg_pkg::SEG_G;
            heading <= snake_seg_pkg::HEAD_LEFT;
        end else if (phase == snake_seg_pkg::PH_WAIT) begin
            pos     <= snake_seg_pkg::SEG_G;
            heading <= snake_seg_pkg::HEAD_LEFT;
        end else begin
            pos     <= snake_seg_pkg::seg_idx_t'(nxt[4:2]);
            heading <= snake_seg_pkg::heading_t'(nxt[1:0]);
        end
    end

endmodule

// ==== rtl/game_ctrl.sv ====
`timescale 1ns/10ps
`include "snake_seg_cfg.svh"

module game_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     press_down,
    input  snake_seg_pkg::seg_idx_t  pos,
    output snake_seg_pkg::phase_t    phase,
    output logic                     tick,
    output snake_seg_pkg::seg_word_u trail
);

    localparam int START_W = $clog2(`SNAKE_START_TICKS + 1);
    localparam int CLEAR_W = $clog2(`SNAKE_CLEAR_TICKS + 1);

    localparam logic [START_W-1:0] START_LAST = START_W'(`SNAKE_START_TICKS);
    localparam logic [CLEAR_W-1:0] CLEAR_LAST = CLEAR_W'(`SNAKE_CLEAR_TICKS);

    logic [`SNAKE_DIV_BITS-1:0] div_q;
    logic [START_W-1:0]         start_cnt;
    logic [CLEAR_W-1:0]         clear_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + `SNAKE_DIV_BITS'(1);
        end
    end

    // One tick on the last count before wrap
    assign tick = &div_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= snake_seg_pkg::PH_WAIT;
            start_cnt <= '0;
            clear_cnt <= '0;
            trail     <= '0;
        end else begin
            case (phase)
                snake_seg_pkg::PH_WAIT: begin
                    if (start_cnt == START_LAST) begin
                        phase     <= snake_seg_pkg::PH_MOVE;
                        start_cnt <= '0;
                    end else if (tick) begin
                        start_cnt <= start_cnt + START_W'(1);
                    end
                end
                snake_seg_pkg::PH_MOVE: begin
                    if (press_down) begin
                        phase     <= snake_seg_pkg::PH_FALL;
                        trail.raw <= '1;
                    end
                end
                snake_seg_pkg::PH_FALL: begin
                    // Erase whatever the snake stands on
                    trail.raw[pos] <= 1'b0;
                    if (trail.raw == '0) begin
                        if (clear_cnt == CLEAR_LAST) begin
                            phase     <= snake_seg_pkg::PH_WAIT;
                            clear_cnt <= '0;
                        end else if (tick) begin
                            clear_cnt <= clear_cnt + CLEAR_W'(1);
                        end
                    end
                end
                default: begin
                    phase <= snake_seg_pkg::PH_WAIT;
                end
            endcase
        end
    end

endmodule

// ==== rtl/segment_driver.sv ====
`timescale 1ns/10ps

module segment_driver (
    input  logic                     clk,
    input  logic                     rst,
    input  snake_seg_pkg::phase_t    phase,
    input  snake_seg_pkg::seg_idx_t  pos,
    input  snake_seg_pkg::seg_word_u trail,
    input  logic                     tick,
    output snake_seg_pkg::seg_word_u seg
);

    logic                     blink_q;
    snake_seg_pkg::seg_word_u lit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink_q <= 1'b0;
        end else if (phase != snake_seg_pkg::PH_FALL) begin
            blink_q <= 1'b0;
        end else if (tick) begin
            blink_q <= ~blink_q;
        end
    end

    always_comb begin
        lit = '0;
        case (phase)
            snake_seg_pkg::PH_WAIT: lit.bits.g = 1'b1;
            snake_seg_pkg::PH_MOVE: lit.raw[pos] = 1'b1;
            snake_seg_pkg::PH_FALL: begin
                lit = trail;
                if (blink_q) begin
                    lit.raw[pos] = 1'b1;
                end
            end
            default: lit = '0;
        endcase
    end

    // Display is active low
    assign seg.raw = ~lit.raw;

endmodule

// ==== rtl/snake_seg_top.sv ====
`timescale 1ns/10ps

module snake_seg_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     btn_right,
    input  logic                     btn_left,
    input  logic                     btn_up,
    input  logic                     btn_down,
    output snake_seg_pkg::seg_word_u seg
);

    logic                     press_right;
    logic                     press_left;
    logic                     press_up;
    logic                     press_down;
    logic                     tick;
    snake_seg_pkg::phase_t    phase;
    snake_seg_pkg::seg_idx_t  pos;
    snake_seg_pkg::heading_t  heading;
    snake_seg_pkg::seg_word_u trail;

    button_conditioner u_buttons (
        .clk         (clk),
        .rst         (rst),
        .btn_right   (btn_right),
        .btn_left    (btn_left),
        .btn_up      (btn_up),
        .btn_down    (btn_down),
        .press_right (press_right),
        .press_left  (press_left),
        .press_up    (press_up),
        .press_down  (press_down)
    );

    segment_walker u_walker (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .press_right (press_right),
        .press_left  (press_left),
        .press_up    (press_up),
        .pos         (pos),
        .heading     (heading)
    );

    game_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .press_down (press_down),
        .pos        (pos),
        .phase      (phase),
        .tick       (tick),
        .trail      (trail)
    );

    segment_driver u_driver (
        .clk   (clk),
        .rst   (rst),
        .phase (phase),
        .pos   (pos),
        .trail (trail),
        .tick  (tick),
        .seg   (seg)
    );

endmodule

// ==== verif/snake_seg_chk.sv ====
`timescale 1ns/10ps

module snake_seg_chk (
    input logic                     clk,
    input logic                     rst,
    input snake_seg_pkg::phase_t    phase,
    input snake_seg_pkg::seg_idx_t  pos,
    input snake_seg_pkg::heading_t  heading,
    input snake_seg_pkg::seg_word_u trail,
    input snake_seg_pkg::seg_word_u seg
);

    int         fail_count = 0;
    logic [6:0] lit;
    logic [6:0] pos_mask;

    assign lit      = ~seg.raw;
    assign pos_mask = 7'd1 << pos;

    // Waiting shows G alone
    wait_only_g: assert property (@(posedge clk) disable iff (rst)
        phase == snake_seg_pkg::PH_WAIT |-> !seg.bits.g && seg.bits.a && seg.bits.b
            && seg.bits.c && seg.bits.d && seg.bits.e && seg.bits.f)
        else begin
            fail_count = fail_count + 1;
            $error("segment other than G lit while waiting");
        end

    // Moving starts from G heading left
    move_entry_home: assert property (@(posedge clk) disable iff (rst)
        (phase == snake_seg_pkg::PH_MOVE && $past(phase) == snake_seg_pkg::PH_WAIT)
            |-> pos == snake_seg_pkg::SEG_G && heading == snake_seg_pkg::HEAD_LEFT)
        else begin
            fail_count = fail_count + 1;
            $error("moving phase did not start at G heading left");
        end

    move_one_lit: assert property (@(posedge clk) disable iff (rst)
        phase == snake_seg_pkg::PH_MOVE |-> $onehot(lit))
        else begin
            fail_count = fail_count + 1;
            $error("moving display does not light exactly one segment");
        end

    fall_entry_full: assert property (@(posedge clk) disable iff (rst)
        (phase == snake_seg_pkg::PH_FALL && $past(phase) == snake_seg_pkg::PH_MOVE)
            |-> (lit | pos_mask) == 7'h7f)
        else begin
            fail_count = fail_count + 1;
            $error("falling did not light the whole digit");
        end

    // Only the blinking head may come back on
    fall_no_new_lit: assert property (@(posedge clk) disable iff (rst)
        (phase == snake_seg_pkg::PH_FALL && $past(phase) == snake_seg_pkg::PH_FALL)
            |-> (lit & ~$past(lit) & ~pos_mask) == 7'd0)
        else begin
            fail_count = fail_count + 1;
            $error("erased segment turned on again");
        end

    fall_trail_shrinks: assert property (@(posedge clk) disable iff (rst)
        (phase == snake_seg_pkg::PH_FALL && $past(phase) == snake_seg_pkg::PH_FALL)
            |-> (trail.raw & ~$past(trail.raw)) == 7'd0)
        else begin
            fail_count = fail_count + 1;
            $error("trail bit was set during falling");
        end

endmodule

// ==== verif/snake_seg_tb.sv ====
`timescale 1ns/10ps
`include "snake_seg_cfg.svh"

module snake_seg_tb;

    localparam int TICK_CYCLES = 1 << `SNAKE_DIV_BITS;
    localparam int HOLD_CYCLES = `SNAKE_DEBOUNCE_LEN + 2;
    localparam int REST_CYCLES = 3;
    localparam int NUM_RANDOM  = 40;
    localparam int MAX_PRESSES = NUM_RANDOM + 24;
    localparam int WAIT_BOUND  = (`SNAKE_START_TICKS + 1) * TICK_CYCLES;
    localparam int CLEAR_BOUND = (`SNAKE_CLEAR_TICKS + 2) * TICK_CYCLES;
    localparam int TIMEOUT     = MAX_PRESSES * (HOLD_CYCLES + REST_CYCLES)
                                 + 2 * WAIT_BOUND + CLEAR_BOUND + 200;
    localparam logic [6:0] ONLY_G = 7'b0111111;

    // Segment, heading and button codes of the move model
    localparam logic [2:0] SA = 3'd0;
    localparam logic [2:0] SB = 3'd1;
    localparam logic [2:0] SC = 3'd2;
    localparam logic [2:0] SD = 3'd3;
    localparam logic [2:0] SE = 3'd4;
    localparam logic [2:0] SF = 3'd5;
    localparam logic [2:0] SG = 3'd6;
    localparam logic [1:0] HR = 2'd0;
    localparam logic [1:0] HL = 2'd1;
    localparam logic [1:0] HU = 2'd2;
    localparam logic [1:0] HD = 2'd3;
    localparam logic [1:0] BR = 2'd0;
    localparam logic [1:0] BL = 2'd1;
    localparam logic [1:0] BU = 2'd2;
    localparam logic [1:0] BD = 2'd3;

    logic                     clk;
    logic                     rst;
    logic                     btn_right;
    logic                     btn_left;
    logic                     btn_up;
    logic                     btn_down;
    snake_seg_pkg::seg_word_u seg;
    logic [2:0]               m_pos;
    logic [1:0]               m_head;
    logic [15:0]              lfsr_q = 16'd894;
    int                       cycles = 0;

    snake_seg_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .btn_right (btn_right),
        .btn_left  (btn_left),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .seg       (seg)
    );

    bind snake_seg_top snake_seg_chk chk0 (
        .clk     (clk),
        .rst     (rst),
        .phase   (phase),
        .pos     (pos),
        .heading (heading),
        .trail   (trail),
        .seg     (seg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    task automatic fail_run(input string what);
        $display("test failed");
        $display("%s", what);
        $fatal(1, "Simulation stopped at the first error");
    endtask

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        fail_run("Watchdog expired before the test sequence finished");
    end

    always @(negedge clk) begin
        if (dut0.chk0.fail_count != 0) begin
            fail_run("A checker assertion on the DUT failed");
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        return b;
    endfunction

    // Figure-eight move giving {position, heading}
    function automatic logic [4:0] model_move(input logic [2:0] p, input logic [1:0] h,
                                              input logic [1:0] b);
        case ({p, h, b})
            {SA, HR, BR}: return {SB, HD};
            {SA, HL, BL}: return {SF, HD};
            {SB, HU, BL}: return {SA, HL};
            {SB, HD, BR}: return {SG, HL};
            {SB, HD, BU}: return {SC, HD};
            {SC, HU, BL}: return {SG, HL};
            {SC, HU, BU}: return {SB, HU};
            {SC, HD, BR}: return {SD, HD};
            {SD, HR, BL}: return {SC, HU};
            {SD, HL, BR}: return {SE, HU};
            {SE, HU, BR}: return {SG, HR};
            {SE, HU, BU}: return {SF, HU};
            {SE, HD, BL}: return {SD, HR};
            {SF, HU, BR}: return {SA, HR};
            {SF, HD, BL}: return {SG, HR};
            {SG, HR, BL}: return {SB, HU};
            {SG, HR, BR}: return {SC, HD};
            {SG, HL, BL}: return {SE, HD};
            {SG, HL, BR}: return {SF, HU};
            default:      return {p, h};
        endcase
    endfunction

    // States from which the G-E-D-C-B-A-F round can no longer be reached
    function automatic logic off_loop(input logic [4:0] s);
        return s == {SB, HU} || s == {SC, HD} || s == {SD, HD}
            || s == {SG, HR} || s == {SA, HL} || s == {SF, HD};
    endfunction

    task automatic set_button(input logic [1:0] b, input logic level);
        case (b)
            BR: btn_right = level;
            BL: btn_left = level;
            BU: btn_up = level;
            default: btn_down = level;
        endcase
    endtask

    // Returns just after the edge where the move shows on seg
    task automatic hold_button(input logic [1:0] b);
        logic [4:0] nxt;
        if (b != BD) begin
            nxt = model_move(m_pos, m_head, b);
            m_pos = nxt[4:2];
            m_head = nxt[1:0];
        end
        set_button(b, 1'b1);
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
        set_button(b, 1'b0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check_seg(input logic [6:0] expected);
        assert (seg.raw == expected) else begin
            fail_run($sformatf("Error at %0d ns: seg expected %b actual %b",
                               $time, expected, seg.raw));
        end
    endtask

    task automatic wait_move(input int since);
        while (dut0.phase != snake_seg_pkg::PH_MOVE) begin
            if (cycles - since > WAIT_BOUND) begin
                fail_run("Wait phase did not end within its tick bound");
            end
            idle_cycles(1);
        end
    endtask

    task automatic press_move(input logic [1:0] b);
        hold_button(b);
        check_seg(~(7'd1 << m_pos));
        idle_cycles(REST_CYCLES);
    endtask

    initial begin
        logic [1:0] b;
        logic [6:0] seen;
        logic       on_round;
        int         since;
        rst = 1'b1;
        btn_right = 1'b0;
        btn_left = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        m_pos = SG;
        m_head = HL;
        idle_cycles(3);
        rst = 1'b0;
        since = cycles;
        // Presses while waiting leave G alone
        hold_button(BR);
        m_pos = SG;
        m_head = HL;
        check_seg(ONLY_G);
        idle_cycles(REST_CYCLES);
        hold_button(BD);
        check_seg(ONLY_G);
        idle_cycles(REST_CYCLES);
        wait_move(since);
        press_move(BL);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            b[1] = rand_bit();
            b[0] = rand_bit();
            if (b == BD) begin
                b = BU;
            end
            if (off_loop(model_move(m_pos, m_head, b))) begin
                b = BL;
            end
            press_move(b);
        end
        hold_button(BD);
        assert ((seg.raw & ~(7'd1 << m_pos)) == 7'd0) else begin
            fail_run($sformatf("Error at %0d ns: seg expected %b actual %b", $time,
                               7'd0, seg.raw & ~(7'd1 << m_pos)));
        end
        idle_cycles(REST_CYCLES);
        // Head for G heading left, then go round until every segment is erased
        seen = 7'd1 << m_pos;
        on_round = 1'b0;
        while (seen != 7'h7f) begin
            on_round = on_round || (m_pos == SG && m_head == HL);
            if (on_round && m_pos == SC) begin
                b = BU;
            end else if (on_round || m_pos == SE || m_pos == SD || m_pos == SC) begin
                b = BL;
            end else begin
                b = BR;
            end
            hold_button(b);
            seen = seen | (7'd1 << m_pos);
            if (seen != 7'h7f) begin
                idle_cycles(REST_CYCLES);
            end
        end
        since = cycles;
        while (seg.raw != ONLY_G) begin
            if (cycles - since > CLEAR_BOUND) begin
                fail_run("Display did not return to G after the trail was cleared");
            end
            idle_cycles(1);
        end
        m_pos = SG;
        m_head = HL;
        wait_move(cycles);
        press_move(BL);
        if (dut0.chk0.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run("The checker reported assertion failures");
        end
    end

endmodule

// ==== snake_seg.f ====
+incdir+rtl
rtl/snake_seg_pkg.sv
rtl/button_conditioner.sv
rtl/segment_walker.sv
rtl/game_ctrl.sv
rtl/segment_driver.sv
rtl/snake_seg_top.sv
verif/snake_seg_chk.sv
verif/snake_seg_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := snake_seg_tb
FILELIST  := snake_seg.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
RUNARGS   := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(RUNARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
